//--- source/wrapper_cfg_pkg.sv
// Wrapper common types
package wrapper_cfg_pkg;

    // Register word, also the entropy word
    typedef logic [31:0] data_t;

    // Full AXI4-Lite address
    typedef logic [31:0] addr_t;

    // Log character from the core
    typedef logic [7:0] char_t;

    // One strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // AXI response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- source/wrapper_regmap_pkg.sv
// Wrapper register map
package wrapper_regmap_pkg;

    import wrapper_cfg_pkg::*;

    // Low address bits seen by the decoder
    localparam int ADDR_DECODE_BITS = 8;

    // Byte offsets, one word each
    localparam logic [ADDR_DECODE_BITS-1:0] VERSION_OFFS       = 8'h00; // Read-only
    localparam logic [ADDR_DECODE_BITS-1:0] CONTROL_OFFS       = 8'h04;
    localparam logic [ADDR_DECODE_BITS-1:0] CYCLE_COUNT_OFFS   = 8'h08;
    localparam logic [ADDR_DECODE_BITS-1:0] ITRNG_DIVISOR_OFFS = 8'h0C;
    localparam logic [ADDR_DECODE_BITS-1:0] LOG_DATA_OFFS      = 8'h10;
    localparam logic [ADDR_DECODE_BITS-1:0] LOG_STATUS_OFFS    = 8'h14;
    localparam logic [ADDR_DECODE_BITS-1:0] ITRNG_DATA_OFFS    = 8'h18; // Write-only
    localparam logic [ADDR_DECODE_BITS-1:0] ITRNG_STATUS_OFFS  = 8'h1C;

    // Control fields
    localparam int CTRL_CPTRA_RST_B_BIT    = 0;
    localparam int CTRL_TRIG_AXI_RESET_BIT = 1;

    // Log data word, character in 7:0
    localparam int LOG_VALID_BIT = 8;

    // Shared by both FIFO status words
    localparam int STAT_EMPTY_BIT  = 0;
    localparam int STAT_FULL_BIT   = 1;
    localparam int ITRNG_FLUSH_BIT = 2;

    localparam data_t FPGA_VERSION = 32'h0001_0203;

endpackage

//--- source/payload_fifo.sv
// Show-ahead payload FIFO
module payload_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     core_clk,
    input  logic     hwif_out,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full,
    output logic     pop_valid,
    output payload_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_ok;
    logic               pop_ok;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign push_ok = push && !full;   // Dropped when full
    assign pop_ok  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else if (flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
            pop_valid <= pop_ok;
        end
    end

    // Storage and popped word
    always_ff @(posedge core_clk) begin
        if (push_ok && !flush) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop_ok) begin
            pop_data <= mem[rd_ptr];
        end
    end

endmodule

//--- source/wrapper_timers.sv
// Reset pulse, throttle and cycle timers
module wrapper_timers
    import wrapper_cfg_pkg::*;
#(
    parameter int AXI_RESET_CYCLES = 16
) (
    input  logic  core_clk,
    input  logic  hwif_out,
    input  logic  cptra_rst_b,
    input  logic  trig_axi_reset,
    input  data_t itrng_divisor,
    input  logic  etrng_req,
    output logic  axi_reset,
    output logic  trng_pop_req,
    output data_t cycle_count
);

    localparam int PULSE_W = $clog2(AXI_RESET_CYCLES + 1);

    logic               trig_q;
    logic               trig_rise;
    logic [PULSE_W-1:0] pulse_cnt;
    data_t              throttle_cnt;

    // A new edge during a pulse is dropped
    assign trig_rise = trig_axi_reset && !trig_q && axi_reset;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            trig_q    <= 1'b0;
            pulse_cnt <= '0;
            axi_reset <= 1'b1;
        end else begin
            trig_q <= trig_axi_reset;
            if (trig_rise) begin
                pulse_cnt <= PULSE_W'(AXI_RESET_CYCLES - 1); // First low cycle counts
                axi_reset <= 1'b0;
            end else if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - 1'b1;
                axi_reset <= 1'b0;
            end else begin
                axi_reset <= 1'b1;
            end
        end
    end

    // Entropy request gate, one pass per divisor period
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
            trng_pop_req <= 1'b0;
        end else if (throttle_cnt == '0) begin
            trng_pop_req <= etrng_req;
            throttle_cnt <= itrng_divisor;
        end else begin
            trng_pop_req <= 1'b0;
            throttle_cnt <= throttle_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!cptra_rst_b) begin
            cycle_count <= '0; // Held while the core sits in reset
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

//--- source/axil_reg_fsm.sv
// AXI4-Lite register block
module axil_reg_fsm
    import wrapper_cfg_pkg::*;
    import wrapper_regmap_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,

    // AXI4-Lite slave
    input  addr_t     s_axil_awaddr,
    input  logic [2:0] s_axil_awprot,
    input  logic      s_axil_awvalid,
    output logic      s_axil_awready,
    input  data_t     s_axil_wdata,
    input  strb_t     s_axil_wstrb,
    input  logic      s_axil_wvalid,
    output logic      s_axil_wready,
    output logic      s_axil_bvalid,
    output axi_resp_t s_axil_bresp,
    input  logic      s_axil_bready,
    input  addr_t     s_axil_araddr,
    input  logic [2:0] s_axil_arprot,
    input  logic      s_axil_arvalid,
    output logic      s_axil_arready,
    output logic      s_axil_rvalid,
    output data_t     s_axil_rdata,
    output axi_resp_t s_axil_rresp,
    input  logic      s_axil_rready,

    // Timers
    input  data_t     cycle_count,
    output logic      cptra_rst_b,
    output logic      trig_axi_reset,
    output data_t     itrng_divisor,

    // Log FIFO
    input  char_t     log_head,
    input  logic      log_empty,
    input  logic      log_full,
    output logic      log_pop,

    // Entropy FIFO
    input  logic      itrng_empty,
    input  logic      itrng_full,
    output logic      itrng_push,
    output data_t     itrng_word,
    output logic      itrng_flush
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_t;

    state_t    state_q;
    logic      wr_accept;
    logic      rd_accept;
    logic [ADDR_DECODE_BITS-1:0] waddr;
    logic [ADDR_DECODE_BITS-1:0] raddr;
    axi_resp_t wr_resp_n;
    axi_resp_t rd_resp_n;
    data_t     rd_data_n;
    axi_resp_t bresp_q;
    axi_resp_t rresp_q;
    data_t     rdata_q;
    data_t     ctrl_q;
    data_t     divisor_q;
    logic      flush_q;

    // Protection and strobes carry no meaning here, writes are always full words
    assign waddr = s_axil_awaddr[ADDR_DECODE_BITS-1:0];
    assign raddr = s_axil_araddr[ADDR_DECODE_BITS-1:0];

    // One transaction in flight, write wins a tie
    assign wr_accept = (state_q == IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign rd_accept = (state_q == IDLE) && s_axil_arvalid && !wr_accept;

    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;
    assign s_axil_arready = rd_accept;
    assign s_axil_bvalid  = (state_q == WRITE_RESP);
    assign s_axil_rvalid  = (state_q == READ_RESP);
    assign s_axil_bresp   = bresp_q;
    assign s_axil_rresp   = rresp_q;
    assign s_axil_rdata   = rdata_q;

    // Writable offsets
    always_comb begin
        case (waddr)
            CONTROL_OFFS,
            ITRNG_DIVISOR_OFFS,
            ITRNG_DATA_OFFS,
            ITRNG_STATUS_OFFS: wr_resp_n = OKAY;
            default:           wr_resp_n = SLVERR;
        endcase
    end

    // Read mux, unmapped and write-only give zero
    always_comb begin
        rd_data_n = '0;
        rd_resp_n = OKAY;
        case (raddr)
            VERSION_OFFS:       rd_data_n = FPGA_VERSION;
            CONTROL_OFFS:       rd_data_n = ctrl_q;
            CYCLE_COUNT_OFFS:   rd_data_n = cycle_count;
            ITRNG_DIVISOR_OFFS: rd_data_n = divisor_q;
            LOG_DATA_OFFS: begin
                if (!log_empty) begin
                    rd_data_n[7:0]           = log_head;
                    rd_data_n[LOG_VALID_BIT] = 1'b1;
                end
            end
            LOG_STATUS_OFFS: begin
                rd_data_n[STAT_EMPTY_BIT] = log_empty;
                rd_data_n[STAT_FULL_BIT]  = log_full;
            end
            ITRNG_STATUS_OFFS: begin
                rd_data_n[STAT_EMPTY_BIT]  = itrng_empty;
                rd_data_n[STAT_FULL_BIT]   = itrng_full;
                rd_data_n[ITRNG_FLUSH_BIT] = flush_q;
            end
            default:            rd_resp_n = SLVERR;
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            state_q   <= IDLE;
            bresp_q   <= OKAY;
            rresp_q   <= OKAY;
            ctrl_q    <= '0;
            divisor_q <= '0;
            flush_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_accept) begin
                        state_q <= WRITE_RESP;
                        bresp_q <= wr_resp_n;
                    end else if (rd_accept) begin
                        state_q <= READ_RESP;
                        rresp_q <= rd_resp_n;
                    end
                end
                WRITE_RESP: if (s_axil_bready) state_q <= IDLE;
                READ_RESP:  if (s_axil_rready) state_q <= IDLE;
                default:    state_q <= IDLE;
            endcase

            if (wr_accept) begin
                case (waddr)
                    CONTROL_OFFS:       ctrl_q    <= s_axil_wdata;
                    ITRNG_DIVISOR_OFFS: divisor_q <= s_axil_wdata;
                    ITRNG_STATUS_OFFS:  flush_q   <= s_axil_wdata[ITRNG_FLUSH_BIT];
                    default: ;
                endcase
            end
        end
    end

    // Sampled when the read is taken, before the pop lands
    always_ff @(posedge core_clk) begin
        if (rd_accept) begin
            rdata_q <= rd_data_n;
        end
    end

    assign cptra_rst_b    = ctrl_q[CTRL_CPTRA_RST_B_BIT];
    assign trig_axi_reset = ctrl_q[CTRL_TRIG_AXI_RESET_BIT];
    assign itrng_divisor  = divisor_q;

    assign log_pop     = rd_accept && (raddr == LOG_DATA_OFFS) && !log_empty;
    assign itrng_push  = wr_accept && (waddr == ITRNG_DATA_OFFS);
    assign itrng_word  = s_axil_wdata;
    assign itrng_flush = flush_q;

endmodule

//--- source/fpga_wrapper_top.sv
// FPGA wrapper top level
module fpga_wrapper_top
    import wrapper_cfg_pkg::*;
#(
    parameter int LOG_FIFO_DEPTH   = 16,
    parameter int ITRNG_FIFO_DEPTH = 8,
    parameter int AXI_RESET_CYCLES = 16
) (
    input  logic       core_clk,
    input  logic       hwif_out,

    input  addr_t      s_axil_awaddr,
    input  logic [2:0] s_axil_awprot,
    input  logic       s_axil_awvalid,
    output logic       s_axil_awready,
    input  data_t      s_axil_wdata,
    input  strb_t      s_axil_wstrb,
    input  logic       s_axil_wvalid,
    output logic       s_axil_wready,
    output logic       s_axil_bvalid,
    output axi_resp_t  s_axil_bresp,
    input  logic       s_axil_bready,
    input  addr_t      s_axil_araddr,
    input  logic [2:0] s_axil_arprot,
    input  logic       s_axil_arvalid,
    output logic       s_axil_arready,
    output logic       s_axil_rvalid,
    output data_t      s_axil_rdata,
    output axi_resp_t  s_axil_rresp,
    input  logic       s_axil_rready,

    input  char_t      log_char,        // From the core's log port
    input  logic       log_char_valid,
    input  logic       etrng_req,
    output data_t      itrng_data,
    output logic       itrng_valid,
    output logic       axi_reset
);

    data_t cycle_count;
    logic  cptra_rst_b;
    logic  trig_axi_reset;
    data_t itrng_divisor;
    logic  trng_pop_req;
    char_t log_head;
    logic  log_empty;
    logic  log_full;
    logic  log_pop;
    logic  itrng_empty;
    logic  itrng_full;
    logic  itrng_push;
    data_t itrng_word;
    logic  itrng_flush;

    axil_reg_fsm u_regs (
        .core_clk, .hwif_out,
        .s_axil_awaddr, .s_axil_awprot, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bvalid, .s_axil_bresp, .s_axil_bready,
        .s_axil_araddr, .s_axil_arprot, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rvalid, .s_axil_rdata, .s_axil_rresp, .s_axil_rready,
        .cycle_count, .cptra_rst_b, .trig_axi_reset, .itrng_divisor,
        .log_head, .log_empty, .log_full, .log_pop,
        .itrng_empty, .itrng_full, .itrng_push, .itrng_word, .itrng_flush
    );

    wrapper_timers #(.AXI_RESET_CYCLES(AXI_RESET_CYCLES)) u_timers (
        .core_clk, .hwif_out, .cptra_rst_b, .trig_axi_reset, .itrng_divisor,
        .etrng_req, .axi_reset, .trng_pop_req, .cycle_count
    );

    // Log characters, popped by host reads, never flushed
    payload_fifo #(.payload_t(char_t), .DEPTH(LOG_FIFO_DEPTH)) u_log_fifo (
        .core_clk, .hwif_out,
        .flush(1'b0), .push(log_char_valid), .push_data(log_char), .pop(log_pop),
        .head(log_head), .empty(log_empty), .full(log_full),
        .pop_valid(), .pop_data()
    );

    payload_fifo #(.payload_t(data_t), .DEPTH(ITRNG_FIFO_DEPTH)) u_itrng_fifo (
        .core_clk, .hwif_out,
        .flush(itrng_flush), .push(itrng_push), .push_data(itrng_word), .pop(trng_pop_req),
        .head(), .empty(itrng_empty), .full(itrng_full),
        .pop_valid(itrng_valid), .pop_data(itrng_data)
    );

endmodule

//--- dv/fpga_wrapper_props.sv
// Wrapper handshake and reset pulse rules
module fpga_wrapper_props #(
    parameter int AXI_RESET_CYCLES = 16
) (
    input logic core_clk,
    input logic hwif_out,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic axi_reset
);

    int low_cnt;

    // Length of the current low stretch on axi_reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            low_cnt <= 0;
        end else if (!axi_reset) begin
            low_cnt <= low_cnt + 1;
        end else begin
            low_cnt <= 0;
        end
    end

    bvalid_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        bvalid && !bready |=> bvalid)
        else $error("BVALID dropped before BREADY");

    rvalid_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        rvalid && !rready |=> rvalid)
        else $error("RVALID dropped before RREADY");

    aw_w_ready_pair: assert property (@(posedge core_clk) disable iff (!hwif_out)
        awready || wready |=> bvalid && $past(awready && wready))
        else $error("AWREADY and WREADY differ or BVALID is late");

    reset_pulse_len: assert property (@(posedge core_clk) disable iff (!hwif_out)
        low_cnt <= AXI_RESET_CYCLES)
        else $error("axi_reset held low too long");

endmodule

// Seen at the top level ports
bind fpga_wrapper_top fpga_wrapper_props #(.AXI_RESET_CYCLES(AXI_RESET_CYCLES)) u_props (
    .core_clk(core_clk), .hwif_out(hwif_out),
    .awready(s_axil_awready), .wready(s_axil_wready),
    .bvalid(s_axil_bvalid), .bready(s_axil_bready),
    .rvalid(s_axil_rvalid), .rready(s_axil_rready),
    .axi_reset(axi_reset)
);

//--- dv/fpga_wrapper_tb.sv
// FPGA wrapper testbench
module fpga_wrapper_tb
    import wrapper_cfg_pkg::*;
    import wrapper_regmap_pkg::*;
();

    localparam int LOG_FIFO_DEPTH   = 16;
    localparam int ITRNG_FIFO_DEPTH = 8;
    localparam int AXI_RESET_CYCLES = 16;
    localparam int TABLE_LEN        = 14;
    localparam int TIMEOUT_CYCLES   = 40 * TABLE_LEN + 2000;
    localparam int TRNG_DIVISOR     = 5;

    localparam data_t CTRL_RUN   = data_t'(1) << CTRL_CPTRA_RST_B_BIT;
    localparam data_t CTRL_TRIG  = data_t'(1) << CTRL_TRIG_AXI_RESET_BIT;
    localparam data_t EMPTY_WORD = data_t'(1) << STAT_EMPTY_BIT;
    localparam data_t FLUSH_WORD = data_t'(1) << ITRNG_FLUSH_BIT;

    typedef enum logic {OP_READ, OP_WRITE} op_t;

    typedef struct packed {
        op_t        op;
        logic [7:0] offs;
        data_t      data;
        data_t      exp_data;   // Reads only
        axi_resp_t  exp_resp;
    } reg_step_t;

    reg_step_t reg_table [TABLE_LEN] = '{
        '{OP_READ,  VERSION_OFFS,       '0,            FPGA_VERSION,  OKAY},
        '{OP_WRITE, VERSION_OFFS,       32'hDEAD_BEEF, '0,            SLVERR},
        '{OP_READ,  VERSION_OFFS,       '0,            FPGA_VERSION,  OKAY},
        '{OP_WRITE, CONTROL_OFFS,       32'hA5A5_0000, '0,            OKAY},
        '{OP_READ,  CONTROL_OFFS,       '0,            32'hA5A5_0000, OKAY},
        '{OP_WRITE, ITRNG_DIVISOR_OFFS, 32'h0000_0023, '0,            OKAY},
        '{OP_READ,  ITRNG_DIVISOR_OFFS, '0,            32'h0000_0023, OKAY},
        '{OP_READ,  8'h40,              '0,            '0,            SLVERR},
        '{OP_WRITE, 8'h40,              32'h1234_5678, '0,            SLVERR},
        '{OP_READ,  ITRNG_DATA_OFFS,    '0,            '0,            SLVERR},
        '{OP_READ,  LOG_STATUS_OFFS,    '0,            EMPTY_WORD,    OKAY},
        '{OP_READ,  ITRNG_STATUS_OFFS,  '0,            EMPTY_WORD,    OKAY},
        '{OP_WRITE, CONTROL_OFFS,       '0,            '0,            OKAY},
        '{OP_READ,  CYCLE_COUNT_OFFS,   '0,            '0,            OKAY}
    };

    string step_name [TABLE_LEN] = '{
        "version_read", "version_write", "version_after_write", "control_write",
        "control_read", "divisor_write", "divisor_read", "unmapped_read",
        "unmapped_write", "itrng_data_read", "log_status_idle", "itrng_status_idle",
        "control_clear", "cycle_held_table"
    };

    logic       core_clk;
    logic       hwif_out;
    addr_t      s_axil_awaddr;
    logic [2:0] s_axil_awprot;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    data_t      s_axil_wdata;
    strb_t      s_axil_wstrb;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    logic       s_axil_bvalid;
    axi_resp_t  s_axil_bresp;
    logic       s_axil_bready;
    addr_t      s_axil_araddr;
    logic [2:0] s_axil_arprot;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    logic       s_axil_rvalid;
    data_t      s_axil_rdata;
    axi_resp_t  s_axil_rresp;
    logic       s_axil_rready;
    char_t      log_char;
    logic       log_char_valid;
    logic       etrng_req;
    data_t      itrng_data;
    logic       itrng_valid;
    logic       axi_reset;

    char_t log_model [$];
    data_t trng_model [$];
    data_t trng_words [$];
    int    trng_stamps [$];
    int    trng_count;
    int    pulse_count;
    int    pulse_len;
    int    low_run;
    int    neg_cycles;
    int    run_cycles;

    fpga_wrapper_top #(
        .LOG_FIFO_DEPTH(LOG_FIFO_DEPTH),
        .ITRNG_FIFO_DEPTH(ITRNG_FIFO_DEPTH),
        .AXI_RESET_CYCLES(AXI_RESET_CYCLES)
    ) dut0 (.*);

    always #2 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        run_cycles++;
        if (run_cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // Port monitors sampled mid-cycle
    always @(negedge core_clk) begin
        neg_cycles++;
        if (hwif_out) begin
            if (!axi_reset) begin
                low_run++;
            end else if (low_run != 0) begin
                pulse_len = low_run; // Pulse just ended
                low_run = 0;
                pulse_count++;
            end
            if (itrng_valid) begin
                trng_words.push_back(itrng_data);
                trng_stamps.push_back(neg_cycles);
                trng_count++;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input data_t exp_val, input data_t act_val);
        if (act_val !== exp_val) begin
            $display("FAIL %s expected %h actual %h", name, exp_val, act_val);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp_val,
                              input axi_resp_t act_val);
        if (act_val !== exp_val) begin
            $display("FAIL %s expected %s actual %s", name, exp_val.name(), act_val.name());
            abort_run("Stopping at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("FAIL %s expected %b actual %b", name, exp_val, act_val);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    task automatic axil_write(input logic [7:0] offs, input data_t data, output axi_resp_t resp);
        @(negedge core_clk);
        s_axil_awaddr  = addr_t'(offs);
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        #1;
        while (!(s_axil_awready && s_axil_wready)) begin
            @(negedge core_clk);
            #1;
        end
        @(negedge core_clk); // Accepted on the edge before
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        #1;
        while (!s_axil_bvalid) begin
            @(negedge core_clk);
            #1;
        end
        resp = s_axil_bresp;
        @(negedge core_clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] offs, output data_t data, output axi_resp_t resp);
        @(negedge core_clk);
        s_axil_araddr  = addr_t'(offs);
        s_axil_arvalid = 1'b1;
        #1;
        while (!s_axil_arready) begin
            @(negedge core_clk);
            #1;
        end
        @(negedge core_clk);
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        #1;
        while (!s_axil_rvalid) begin
            @(negedge core_clk);
            #1;
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge core_clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic reg_write(input string name, input logic [7:0] offs, input data_t data);
        axi_resp_t resp;
        axil_write(offs, data, resp);
        check_resp(name, OKAY, resp);
    endtask

    task automatic reg_read(input string name, input logic [7:0] offs, output data_t data);
        axi_resp_t resp;
        axil_read(offs, data, resp);
        check_resp(name, OKAY, resp);
    endtask

    // One character per cycle and the model drops what the FIFO cannot hold
    task automatic push_log_chars(input int n);
        char_t c;
        for (int i = 0; i < n; i++) begin
            @(negedge core_clk);
            c = char_t'($urandom());
            log_char       = c;
            log_char_valid = 1'b1;
            if (log_model.size() < LOG_FIFO_DEPTH) begin
                log_model.push_back(c);
            end
        end
        @(negedge core_clk);
        log_char_valid = 1'b0;
    endtask

    task automatic drain_log(input string name);
        data_t rdata;
        data_t expected;
        while (log_model.size() != 0) begin
            expected                = '0;
            expected[7:0]           = log_model.pop_front();
            expected[LOG_VALID_BIT] = 1'b1;
            reg_read(name, LOG_DATA_OFFS, rdata);
            check_word(name, expected, rdata);
        end
        reg_read(name, LOG_DATA_OFFS, rdata);
        check_bit({name, "_empty_read"}, 1'b0, rdata[LOG_VALID_BIT]);
        reg_read(name, LOG_STATUS_OFFS, rdata);
        check_bit({name, "_status_empty"}, 1'b1, rdata[STAT_EMPTY_BIT]);
    endtask

    task automatic push_trng_words(input int n);
        data_t word;
        for (int i = 0; i < n; i++) begin
            word = $urandom();
            reg_write($sformatf("itrng_push_%0d", i), ITRNG_DATA_OFFS, word);
            trng_model.push_back(word);
        end
    endtask

    initial begin
        axi_resp_t resp;
        data_t     rdata;
        data_t     first_count;
        int        base_pulses;
        int        base_words;
        void'($urandom(70));
        core_clk       = 1'b0;
        hwif_out       = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awprot  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        log_char       = '0;
        log_char_valid = 1'b0;
        etrng_req      = 1'b0;
        repeat (2) @(posedge core_clk);
        @(negedge core_clk);
        hwif_out = 1'b1;

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (reg_table[i].op == OP_WRITE) begin
                axil_write(reg_table[i].offs, reg_table[i].data, resp);
            end else begin
                axil_read(reg_table[i].offs, rdata, resp);
                check_word(step_name[i], reg_table[i].exp_data, rdata);
            end
            check_resp(step_name[i], reg_table[i].exp_resp, resp);
        end

        // Log FIFO order and overflow
        push_log_chars(5);
        drain_log("log_order");
        push_log_chars(LOG_FIFO_DEPTH + 3);
        reg_read("log_full_status", LOG_STATUS_OFFS, rdata);
        check_bit("log_full", 1'b1, rdata[STAT_FULL_BIT]);
        drain_log("log_full_drain");

        // Reset pulse with a held trigger and a re-arm
        base_pulses = pulse_count;
        reg_write("trig_set", CONTROL_OFFS, CTRL_TRIG);
        wait (pulse_count == base_pulses + 1);
        check_word("trig_pulse_len", data_t'(AXI_RESET_CYCLES), data_t'(pulse_len));
        reg_write("trig_hold", CONTROL_OFFS, CTRL_TRIG);
        repeat (AXI_RESET_CYCLES + 8) @(negedge core_clk);
        check_word("trig_no_repulse", data_t'(base_pulses + 1), data_t'(pulse_count));
        reg_write("trig_clear", CONTROL_OFFS, '0);
        reg_write("trig_rearm", CONTROL_OFFS, CTRL_TRIG);
        wait (pulse_count == base_pulses + 2);
        check_word("trig_pulse_len_2", data_t'(AXI_RESET_CYCLES), data_t'(pulse_len));

        reg_read("cycle_held", CYCLE_COUNT_OFFS, rdata);
        check_word("cycle_held", '0, rdata);
        reg_write("core_run", CONTROL_OFFS, CTRL_RUN);
        reg_read("cycle_first", CYCLE_COUNT_OFFS, first_count);
        reg_read("cycle_second", CYCLE_COUNT_OFFS, rdata);
        check_bit("cycle_nonzero", 1'b1, first_count != '0);
        check_bit("cycle_increasing", 1'b1, rdata > first_count);

        // Entropy words out under the throttle
        reg_write("divisor_set", ITRNG_DIVISOR_OFFS, data_t'(TRNG_DIVISOR));
        push_trng_words(4);
        base_words = trng_count;
        @(negedge core_clk);
        etrng_req = 1'b1;
        wait (trng_count == base_words + 4);
        @(negedge core_clk);
        etrng_req = 1'b0;
        for (int i = 0; i < 4; i++) begin
            check_word($sformatf("itrng_word_%0d", i), trng_model.pop_front(),
                       trng_words[base_words + i]);
            if (i > 0) begin
                check_bit($sformatf("itrng_gap_%0d", i), 1'b1,
                          trng_stamps[base_words + i] - trng_stamps[base_words + i - 1]
                          >= TRNG_DIVISOR + 1);
            end
        end
        reg_read("itrng_drained", ITRNG_STATUS_OFFS, rdata);
        check_word("itrng_drained", EMPTY_WORD, rdata);

        push_trng_words(3);
        trng_model.delete(); // Flushed below
        reg_write("flush_set", ITRNG_STATUS_OFFS, FLUSH_WORD);
        reg_read("flush_status", ITRNG_STATUS_OFFS, rdata);
        check_word("flush_status", FLUSH_WORD | EMPTY_WORD, rdata);
        reg_write("flush_clear", ITRNG_STATUS_OFFS, '0);
        reg_read("flush_done", ITRNG_STATUS_OFFS, rdata);
        check_word("flush_done", EMPTY_WORD, rdata);
        base_words = trng_count;
        @(negedge core_clk);
        etrng_req = 1'b1;
        repeat (4 * (TRNG_DIVISOR + 1)) @(negedge core_clk);
        etrng_req = 1'b0;
        check_word("flush_no_output", data_t'(base_words), data_t'(trng_count));

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- compile.f
source/wrapper_cfg_pkg.sv
source/wrapper_regmap_pkg.sv
source/payload_fifo.sv
source/wrapper_timers.sv
source/axil_reg_fsm.sv
source/fpga_wrapper_top.sv
dv/fpga_wrapper_props.sv
dv/fpga_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpga_wrapper_tb -f compile.f -o sim_fpga_wrapper

status=0
./obj_dir/sim_fpga_wrapper > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation did not finish cleanly"
    exit 1
fi
echo "Simulation passed"
